// ==== rtl/mcr3_input_pkg.sv ====
// Shared game codes, widths and output-latch bit positions for the arcade input mapper
`default_nettype none

package mcr3_input_pkg;

	// ====================
	// Game select
	// ====================

	// Codes not listed here select no game
	typedef enum logic [6:0] {
		GAME_RAMPAGE  = 7'd0,
		GAME_POWERDRV = 7'd2,
		GAME_DEMODERB = 7'd4,
		GAME_TIMBER   = 7'd6,
		GAME_TAPPER   = 7'd7
	} game_e;

	// ====================
	// Widths
	// ====================

	localparam int WHEEL_W     = 6;
	localparam int NUM_PLAYERS = 4;

	// CPU-side input and output bytes
	typedef logic [7:0] port_byte_t;

	// ====================
	// Output latch 6
	// ====================

	// Wheel-bank select control, clear wins over set
	localparam int OUT6_SEL_CLR = 7;
	localparam int OUT6_SEL_SET = 6;

endpackage

`default_nettype wire

// ==== rtl/player_if.sv ====
// One player's active-high control set, driven by the top level and read by the input blocks
`timescale 1ns/1ps
`default_nettype none

interface player_if;

	// Joystick
	logic up;
	logic down;
	logic left;
	logic right;

	// Buttons, coin and start
	logic fire_a;
	logic fire_b;
	logic fire_c;
	logic fire_d;
	logic coin;
	logic start;

	modport source (
		output up, down, left, right,
		output fire_a, fire_b, fire_c, fire_d, coin, start
	);

	modport sink (
		input up, down, left, right,
		input fire_a, fire_b, fire_c, fire_d, coin, start
	);

endinterface

`default_nettype wire

// ==== rtl/wheel_spinner.sv ====
// Wheel position counter, stepped once per vsync rise by a player's left and right
`timescale 1ns/1ps
`default_nettype none

module wheel_spinner import mcr3_input_pkg::*; (
	input  logic               clk_sys,
	input  logic               reset,
	input  logic               vsync_i,
	input  logic               left_i,
	input  logic               right_i,
	output logic [WHEEL_W-1:0] wheel_o
);

	logic vsync_q;
	logic vsync_rise;

	assign vsync_rise = vsync_i && !vsync_q;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			vsync_q <= 1'b0;
			wheel_o <= '0;
		end else begin
			vsync_q <= vsync_i;
			// Both or neither held leaves the wheel where it is
			if (vsync_rise && right_i && !left_i)
				wheel_o <= wheel_o + 1'b1;
			else if (vsync_rise && left_i && !right_i)
				wheel_o <= wheel_o - 1'b1;
		end
	end

	// Single steps, and only in the cycle after a vsync rise
	assert property (@(posedge clk_sys) disable iff (reset)
		(!$past(reset) && wheel_o != $past(wheel_o)) |->
			($past(vsync_rise) &&
			 (wheel_o == $past(wheel_o) + WHEEL_W'(1) ||
			  wheel_o == $past(wheel_o) - WHEEL_W'(1))));

endmodule

`default_nettype wire

// ==== rtl/derby_wheels.sv ====
// Demolition Derby wheels for four players and the CPU-written bank select that picks two
`timescale 1ns/1ps
`default_nettype none

module derby_wheels import mcr3_input_pkg::*; (
	input  logic               clk_sys,
	input  logic               reset,
	input  logic               vsync_i,
	player_if.sink             p1,
	player_if.sink             p2,
	player_if.sink             p3,
	player_if.sink             p4,
	input  logic               out6_wr_i,
	input  port_byte_t         out6_data_i,
	output logic [WHEEL_W-1:0] wheel_lo_o,
	output logic [WHEEL_W-1:0] wheel_hi_o
);

	logic [WHEEL_W-1:0] wheel [NUM_PLAYERS];
	logic               sel;

	// ====================
	// Spinners
	// ====================

	wheel_spinner wheel_spinner_p1_i (
		.clk_sys (clk_sys),
		.reset   (reset),
		.vsync_i (vsync_i),
		.left_i  (p1.left),
		.right_i (p1.right),
		.wheel_o (wheel[0])
	);

	wheel_spinner wheel_spinner_p2_i (
		.clk_sys (clk_sys),
		.reset   (reset),
		.vsync_i (vsync_i),
		.left_i  (p2.left),
		.right_i (p2.right),
		.wheel_o (wheel[1])
	);

	wheel_spinner wheel_spinner_p3_i (
		.clk_sys (clk_sys),
		.reset   (reset),
		.vsync_i (vsync_i),
		.left_i  (p3.left),
		.right_i (p3.right),
		.wheel_o (wheel[2])
	);

	wheel_spinner wheel_spinner_p4_i (
		.clk_sys (clk_sys),
		.reset   (reset),
		.vsync_i (vsync_i),
		.left_i  (p4.left),
		.right_i (p4.right),
		.wheel_o (wheel[3])
	);

	// ====================
	// Bank select latch
	// ====================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			sel <= 1'b0;
		end else if (out6_wr_i) begin
			if (out6_data_i[OUT6_SEL_CLR])
				sel <= 1'b0;
			else if (out6_data_i[OUT6_SEL_SET])
				sel <= 1'b1;
		end
	end

	// Bank 1 is wheels 3 and 4
	assign wheel_lo_o = sel ? wheel[2] : wheel[0];
	assign wheel_hi_o = sel ? wheel[3] : wheel[1];

	// A write with both bits set must end up cleared
	assert property (@(posedge clk_sys) disable iff (reset)
		(out6_wr_i && out6_data_i[OUT6_SEL_CLR] && out6_data_i[OUT6_SEL_SET]) |=> !sel);

endmodule

`default_nettype wire

// ==== rtl/gear_toggles.sv ====
// Power Drive gear shift bits, one per player, flipped by each press of fire_d
`timescale 1ns/1ps
`default_nettype none

module gear_toggles import mcr3_input_pkg::*; (
	input  logic   clk_sys,
	input  logic   reset,
	player_if.sink p1,
	player_if.sink p2,
	player_if.sink p3,
	output logic [2:0] gear_o
);

	logic [2:0] fire_d_now;
	logic [2:0] fire_d_q;
	logic [2:0] fire_d_rise;

	// Bit n is player n+1
	assign fire_d_now  = {p3.fire_d, p2.fire_d, p1.fire_d};
	assign fire_d_rise = fire_d_now & ~fire_d_q;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			fire_d_q <= '0;
			gear_o   <= '0;
		end else begin
			fire_d_q <= fire_d_now;
			// Holding the button does not shift again
			gear_o   <= gear_o ^ fire_d_rise;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/input_port_mux.sv ====
// Per-game layout of the five active-low input bytes read by the game CPU, registered
`timescale 1ns/1ps
`default_nettype none

module input_port_mux import mcr3_input_pkg::*; (
	input  logic               clk_sys,
	input  logic               reset,
	input  game_e              game_i,
	input  logic               service_i,
	input  logic [3:0]         dip_i,
	player_if.sink             p1,
	player_if.sink             p2,
	player_if.sink             p3,
	player_if.sink             p4,
	input  logic [2:0]         gear_i,
	input  logic [WHEEL_W-1:0] wheel_lo_i,
	input  logic [WHEEL_W-1:0] wheel_hi_i,
	output port_byte_t         in0_o,
	output port_byte_t         in1_o,
	output port_byte_t         in2_o,
	output port_byte_t         in3_o,
	output port_byte_t         in4_o
);

	// Active-high bytes, inverted on the way into the registers
	port_byte_t b0;
	port_byte_t b1;
	port_byte_t b2;
	port_byte_t b3;
	port_byte_t b4;

	// ====================
	// Game layouts
	// ====================

	always_comb begin
		b0 = '0;
		b1 = '0;
		b2 = '0;
		b3 = '0;
		b4 = '0;
		case (game_i)
			GAME_RAMPAGE: begin
				b0 = {2'b00, service_i, 3'b000, p2.coin, p1.coin};
				b1 = {2'b00, p1.fire_b, p1.fire_a, p1.left, p1.down, p1.right, p1.up};
				b2 = {2'b00, p2.fire_b, p2.fire_a, p2.left, p2.down, p2.right, p2.up};
				b3 = {dip_i[3], 4'b0000, dip_i[2:0]};
				// Third player sits on the extra port
				b4 = {2'b00, p3.fire_b, p3.fire_a, p3.left, p3.down, p3.right, p3.up};
			end
			GAME_POWERDRV: begin
				b0 = {2'b00, service_i, 2'b00, p3.coin, p2.coin, p1.coin};
				b1 = {p2.fire_b, p2.fire_a, gear_i[1], p2.fire_c,
				      p1.fire_b, p1.fire_a, gear_i[0], p1.fire_c};
				b2 = {4'b0000, p3.fire_b, p3.fire_a, gear_i[2], p3.fire_c};
				b3 = {dip_i, 4'b0000};
			end
			GAME_DEMODERB: begin
				b0 = {2'b00, service_i, 1'b0, p2.start, p1.start, p2.coin, p1.coin};
				b1 = {wheel_lo_i, p1.fire_b, p1.fire_a};
				b2 = {wheel_hi_i, p2.fire_b, p2.fire_a};
				b3 = {4'b0000, dip_i};
				b4 = {p4.fire_b, p4.fire_a, p3.fire_b, p3.fire_a,
				      p4.start, p3.start, p4.coin, p3.coin};
			end
			GAME_TIMBER, GAME_TAPPER: begin
				b0 = {service_i, 3'b000, p2.start, p1.start, p2.coin, p1.coin};
				b1 = {2'b00, p1.fire_b, p1.fire_a, p1.up, p1.down, p1.left, p1.right};
				b2 = {2'b00, p2.fire_b, p2.fire_a, p2.up, p2.down, p2.left, p2.right};
				b3 = {1'b0, dip_i[1], 3'b000, dip_i[2], 2'b00};
			end
			// Unknown code, nothing pressed
			default: ;
		endcase
	end

	// ====================
	// Output registers
	// ====================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			in0_o <= 8'hff;
			in1_o <= 8'hff;
			in2_o <= 8'hff;
			in3_o <= 8'hff;
			in4_o <= 8'hff;
		end else begin
			in0_o <= ~b0;
			in1_o <= ~b1;
			in2_o <= ~b2;
			in3_o <= ~b3;
			in4_o <= ~b4;
		end
	end

	// Only two games use the extra port
	assert property (@(posedge clk_sys) disable iff (reset)
		!($past(game_i) inside {GAME_RAMPAGE, GAME_DEMODERB}) |-> in4_o == 8'hff);

endmodule

`default_nettype wire

// ==== rtl/mcr3_input_top.sv ====
// Top level of the input mapper, bundling the player ports and wiring gears, wheels and mux
`timescale 1ns/1ps
`default_nettype none

module mcr3_input_top import mcr3_input_pkg::*; (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  game_e                  game_i,
	input  logic                   service_i,
	input  logic [3:0]             dip_i,
	// Up, down, left, right from bit 3
	input  logic [3:0]             p1_dir_i,
	input  logic [3:0]             p2_dir_i,
	input  logic [3:0]             p3_dir_i,
	input  logic [3:0]             p4_dir_i,
	// Fire_d down to fire_a
	input  logic [3:0]             p1_btn_i,
	input  logic [3:0]             p2_btn_i,
	input  logic [3:0]             p3_btn_i,
	input  logic [3:0]             p4_btn_i,
	input  logic [NUM_PLAYERS-1:0] coin_i,
	input  logic [NUM_PLAYERS-1:0] start_i,
	input  logic                   vsync_i,
	input  logic                   out6_wr_i,
	input  port_byte_t             out6_data_i,
	output port_byte_t             in0_o,
	output port_byte_t             in1_o,
	output port_byte_t             in2_o,
	output port_byte_t             in3_o,
	output port_byte_t             in4_o
);

	player_if p1 ();
	player_if p2 ();
	player_if p3 ();
	player_if p4 ();

	logic [2:0]         gear;
	logic [WHEEL_W-1:0] wheel_lo;
	logic [WHEEL_W-1:0] wheel_hi;

	// ====================
	// Player bundles
	// ====================

	assign {p1.up, p1.down, p1.left, p1.right} = p1_dir_i;
	assign {p2.up, p2.down, p2.left, p2.right} = p2_dir_i;
	assign {p3.up, p3.down, p3.left, p3.right} = p3_dir_i;
	assign {p4.up, p4.down, p4.left, p4.right} = p4_dir_i;

	assign {p1.fire_d, p1.fire_c, p1.fire_b, p1.fire_a} = p1_btn_i;
	assign {p2.fire_d, p2.fire_c, p2.fire_b, p2.fire_a} = p2_btn_i;
	assign {p3.fire_d, p3.fire_c, p3.fire_b, p3.fire_a} = p3_btn_i;
	assign {p4.fire_d, p4.fire_c, p4.fire_b, p4.fire_a} = p4_btn_i;

	assign {p4.coin, p3.coin, p2.coin, p1.coin}     = coin_i;
	assign {p4.start, p3.start, p2.start, p1.start} = start_i;

	// ====================
	// Blocks
	// ====================

	gear_toggles gear_toggles_i (
		.clk_sys (clk_sys),
		.reset   (reset),
		.p1      (p1),
		.p2      (p2),
		.p3      (p3),
		.gear_o  (gear)
	);

	derby_wheels derby_wheels_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.vsync_i     (vsync_i),
		.p1          (p1),
		.p2          (p2),
		.p3          (p3),
		.p4          (p4),
		.out6_wr_i   (out6_wr_i),
		.out6_data_i (out6_data_i),
		.wheel_lo_o  (wheel_lo),
		.wheel_hi_o  (wheel_hi)
	);

	input_port_mux input_port_mux_i (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.game_i     (game_i),
		.service_i  (service_i),
		.dip_i      (dip_i),
		.p1         (p1),
		.p2         (p2),
		.p3         (p3),
		.p4         (p4),
		.gear_i     (gear),
		.wheel_lo_i (wheel_lo),
		.wheel_hi_i (wheel_hi),
		.in0_o      (in0_o),
		.in1_o      (in1_o),
		.in2_o      (in2_o),
		.in3_o      (in3_o),
		.in4_o      (in4_o)
	);

endmodule

`default_nettype wire

// ==== tests/input_checker.sv ====
// Reference model of the input mapper, compares all five bytes after every clock edge
`timescale 1ns/1ps
`default_nettype none

module input_checker import mcr3_input_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  game_e       game_i,
	input  logic        service_i,
	input  logic [3:0]  dip_i,
	input  logic [15:0] dirs_i,
	input  logic [15:0] btns_i,
	input  logic [3:0]  coin_i,
	input  logic [3:0]  start_i,
	input  logic        vsync_i,
	input  logic        out6_wr_i,
	input  port_byte_t  out6_data_i,
	input  logic [39:0] bytes_i,
	output int unsigned mismatch_count_o,
	output int unsigned check_count_o
);

	// Model state
	logic [2:0]         gear;
	logic [2:0]         fire_d_q;
	logic [WHEEL_W-1:0] wheel [NUM_PLAYERS];
	logic               vsync_q;
	logic               sel;
	logic [39:0]        expected;
	logic [6:0]         expected_game;
	logic               expected_valid = 1'b0;

	function automatic string game_name(logic [6:0] game);
		case (game)
			GAME_RAMPAGE:  return "rampage";
			GAME_POWERDRV: return "powerdrv";
			GAME_DEMODERB: return "demoderb";
			GAME_TIMBER:   return "timber";
			GAME_TAPPER:   return "tapper";
			default:       return "unknown";
		endcase
	endfunction

	// ====================
	// Byte layouts
	// ====================

	// Returns {in4, in3, in2, in1, in0} active low as the CPU sees them
	function automatic logic [39:0] layout(logic [6:0] game, logic svc, logic [3:0] dip,
			logic [15:0] dirs, logic [15:0] btns, logic [3:0] coin, logic [3:0] start,
			logic [2:0] gr, logic [WHEEL_W-1:0] wlo, logic [WHEEL_W-1:0] whi);
		port_byte_t b [5];
		logic [3:0] d;
		logic [3:0] k;
		int         idx;
		foreach (b[i])
			b[i] = '0;
		case (game)
			GAME_RAMPAGE: begin
				b[0][5]   = svc;
				b[0][1:0] = coin[1:0];
				b[3][7]   = dip[3];
				b[3][2:0] = dip[2:0];
				for (int p = 0; p < 3; p++) begin
					d = dirs[4*p +: 4];
					k = btns[4*p +: 4];
					idx = (p == 2) ? 4 : p + 1;
					// Left, down, right, up
					b[idx][5:0] = {k[1], k[0], d[1], d[2], d[0], d[3]};
				end
			end
			GAME_POWERDRV: begin
				b[0][5]   = svc;
				b[0][2:0] = coin[2:0];
				b[1][3:0] = {btns[1], btns[0], gr[0], btns[2]};
				b[1][7:4] = {btns[5], btns[4], gr[1], btns[6]};
				b[2][3:0] = {btns[9], btns[8], gr[2], btns[10]};
				b[3][7:4] = dip;
			end
			GAME_DEMODERB: begin
				b[0][5]   = svc;
				b[0][3:0] = {start[1], start[0], coin[1], coin[0]};
				b[1]      = {wlo, btns[1], btns[0]};
				b[2]      = {whi, btns[5], btns[4]};
				b[3][3:0] = dip;
				b[4] = {btns[13], btns[12], btns[9], btns[8], start[3], start[2], coin[3], coin[2]};
			end
			GAME_TIMBER, GAME_TAPPER: begin
				b[0][7]   = svc;
				b[0][3:0] = {start[1], start[0], coin[1], coin[0]};
				b[1][5:0] = {btns[1], btns[0], dirs[3:0]};
				b[2][5:0] = {btns[5], btns[4], dirs[7:4]};
				b[3][6]   = dip[1];
				b[3][2]   = dip[2];
			end
			default: ;
		endcase
		return ~{b[4], b[3], b[2], b[1], b[0]};
	endfunction

	function automatic int check_byte(string name, port_byte_t exp_b, port_byte_t act_b);
		if (exp_b !== act_b) begin
			$display("MISMATCH %s expected %02h actual %02h", name, exp_b, act_b);
			return 1;
		end
		return 0;
	endfunction

	// ====================
	// Compare first and then step the model
	// ====================

	always @(posedge clk_sys) begin : model
		logic [2:0] fire_d;
		logic       vsync_rise;
		int         bad;
		bad = 0;
		if (expected_valid) begin
			for (int i = 0; i < 5; i++)
				bad += check_byte($sformatf("%s in%0d", game_name(expected_game), i),
					expected[8*i +: 8], bytes_i[8*i +: 8]);
			mismatch_count_o <= mismatch_count_o + bad;
			check_count_o    <= check_count_o + 1;
		end
		if (reset) begin
			gear     = '0;
			fire_d_q = '0;
			vsync_q  = 1'b0;
			sel      = 1'b0;
			foreach (wheel[p])
				wheel[p] = '0;
			expected = '1;
		end else begin
			expected = layout(game_i, service_i, dip_i, dirs_i, btns_i, coin_i, start_i, gear,
				sel ? wheel[2] : wheel[0], sel ? wheel[3] : wheel[1]);
			fire_d     = {btns_i[11], btns_i[7], btns_i[3]};
			gear       = gear ^ (fire_d & ~fire_d_q);
			fire_d_q   = fire_d;
			vsync_rise = vsync_i && !vsync_q;
			vsync_q    = vsync_i;
			// Bit 0 of a direction nibble is right and bit 1 is left
			foreach (wheel[p]) begin
				if (vsync_rise && dirs_i[4*p] && !dirs_i[4*p+1])
					wheel[p] = wheel[p] + 1'b1;
				else if (vsync_rise && dirs_i[4*p+1] && !dirs_i[4*p])
					wheel[p] = wheel[p] - 1'b1;
			end
			if (out6_wr_i) begin
				if (out6_data_i[OUT6_SEL_CLR])
					sel = 1'b0;
				else if (out6_data_i[OUT6_SEL_SET])
					sel = 1'b1;
			end
		end
		expected_game  = game_i;
		expected_valid = 1'b1;
	end

endmodule

`default_nettype wire

// ==== tests/tb_mcr3_input.sv ====
// Testbench for the input mapper, drives random controls through every game and counts errors
`timescale 1ns/1ps
`default_nettype none

module tb_mcr3_input import mcr3_input_pkg::*; ();

	localparam int SEG_CYCLES = 300;
	localparam int MAX_CYCLES = 5000;
	localparam int IDLE_LIMIT = 64;

	logic        clk_sys = 1'b0;
	logic        reset;
	game_e       game;
	logic        service;
	logic [3:0]  dip;
	logic [3:0]  p1_dir;
	logic [3:0]  p2_dir;
	logic [3:0]  p3_dir;
	logic [3:0]  p4_dir;
	logic [3:0]  p1_btn;
	logic [3:0]  p2_btn;
	logic [3:0]  p3_btn;
	logic [3:0]  p4_btn;
	logic [3:0]  coin;
	logic [3:0]  start;
	logic        vsync;
	logic        out6_wr;
	port_byte_t  out6_data;
	port_byte_t  in0;
	port_byte_t  in1;
	port_byte_t  in2;
	port_byte_t  in3;
	port_byte_t  in4;
	int unsigned mismatch_count;
	int unsigned check_count;
	int unsigned other_errors = 0;
	logic [31:0] lfsr;
	int          vsync_left;

	// Five games plus one code that selects nothing
	// Power Drive follows Demolition Derby so that gears cleared by the mid-run reset show up
	logic [6:0]  game_codes [6] = '{7'd0, 7'd4, 7'd2, 7'd6, 7'd7, 7'd5};

	always #4 clk_sys = ~clk_sys;

	mcr3_input_top mcr3_input_top_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.game_i      (game),
		.service_i   (service),
		.dip_i       (dip),
		.p1_dir_i    (p1_dir),
		.p2_dir_i    (p2_dir),
		.p3_dir_i    (p3_dir),
		.p4_dir_i    (p4_dir),
		.p1_btn_i    (p1_btn),
		.p2_btn_i    (p2_btn),
		.p3_btn_i    (p3_btn),
		.p4_btn_i    (p4_btn),
		.coin_i      (coin),
		.start_i     (start),
		.vsync_i     (vsync),
		.out6_wr_i   (out6_wr),
		.out6_data_i (out6_data),
		.in0_o       (in0),
		.in1_o       (in1),
		.in2_o       (in2),
		.in3_o       (in3),
		.in4_o       (in4)
	);

	input_checker input_checker_i (
		.clk_sys          (clk_sys),
		.reset            (reset),
		.game_i           (game),
		.service_i        (service),
		.dip_i            (dip),
		.dirs_i           ({p4_dir, p3_dir, p2_dir, p1_dir}),
		.btns_i           ({p4_btn, p3_btn, p2_btn, p1_btn}),
		.coin_i           (coin),
		.start_i          (start),
		.vsync_i          (vsync),
		.out6_wr_i        (out6_wr),
		.out6_data_i      (out6_data),
		.bytes_i          ({in4, in3, in2, in1, in0}),
		.mismatch_count_o (mismatch_count),
		.check_count_o    (check_count)
	);

	// ====================
	// Random bits
	// ====================

	function automatic logic [31:0] lfsr_step(logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	function automatic logic [31:0] take_bits(int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r[i] = lfsr[0];
			lfsr = lfsr_step(lfsr);
		end
		return r;
	endfunction

	// One clock of stimulus where controls change only now and then so buttons get held
	task automatic drive_cycle(input logic [6:0] code, input logic rst);
		@(posedge clk_sys);
		reset <= rst;
		game  <= game_e'(code);
		if (take_bits(2) == 0) begin
			p1_dir <= 4'(take_bits(4));
			p2_dir <= 4'(take_bits(4));
			p3_dir <= 4'(take_bits(4));
			p4_dir <= 4'(take_bits(4));
			p1_btn <= 4'(take_bits(4));
			p2_btn <= 4'(take_bits(4));
			p3_btn <= 4'(take_bits(4));
			p4_btn <= 4'(take_bits(4));
			coin   <= 4'(take_bits(4));
			start  <= 4'(take_bits(4));
		end
		service   <= (take_bits(4) == 0);
		dip       <= 4'(take_bits(4));
		out6_wr   <= (take_bits(4) == 0);
		out6_data <= 8'(take_bits(8));
		// Slow vsync with a jittered half period
		if (vsync_left == 0) begin
			vsync      <= ~vsync;
			vsync_left = 12 + int'(take_bits(3));
		end else begin
			vsync_left--;
		end
	endtask

	initial begin : stimulus
		int start_count;
		int n;
		lfsr = 32'h53590783;
		vsync_left = 12;
		reset = 1'b1;
		game = GAME_RAMPAGE;
		service = 1'b0;
		dip = '0;
		{p1_dir, p2_dir, p3_dir, p4_dir} = '0;
		{p1_btn, p2_btn, p3_btn, p4_btn} = '0;
		coin = '0;
		start = '0;
		vsync = 1'b0;
		out6_wr = 1'b0;
		out6_data = '0;
		repeat (4) @(posedge clk_sys);
		reset <= 1'b0;
		// Mid-run reset lands inside the Demolition Derby segment
		for (int seg = 0; seg < 6; seg++)
			for (int cyc = 0; cyc < SEG_CYCLES; cyc++)
				drive_cycle(game_codes[seg], seg == 1 && cyc >= 150 && cyc < 154);
		start_count = check_count;
		n = 0;
		while (check_count < start_count + 2 && n < 16) begin
			@(posedge clk_sys);
			n++;
		end
		if (check_count < start_count + 2) begin
			$display("Checker stopped comparing at the end of the run");
			other_errors++;
		end
		$display("Errors: %0d mismatches, %0d other, %0d edges checked",
			mismatch_count, other_errors, check_count);
		if (mismatch_count == 0 && other_errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

	// ====================
	// Watchdog
	// ====================

	initial begin : watchdog
		int unsigned last;
		int          idle;
		idle = 0;
		last = 0;
		for (int cyc = 0; cyc < MAX_CYCLES && idle < IDLE_LIMIT; cyc++) begin
			@(posedge clk_sys);
			idle = (check_count == last) ? idle + 1 : 0;
			last = check_count;
		end
		if (idle >= IDLE_LIMIT)
			$display("Run stalled, no comparison for %0d cycles", IDLE_LIMIT);
		else
			$display("Run did not finish within %0d cycles", MAX_CYCLES);
		$display("Errors: %0d mismatches, %0d other, %0d edges checked",
			mismatch_count, other_errors + 1, check_count);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sources.f ====
rtl/mcr3_input_pkg.sv
rtl/player_if.sv
rtl/wheel_spinner.sv
rtl/derby_wheels.sv
rtl/gear_toggles.sv
rtl/input_port_mux.sv
rtl/mcr3_input_top.sv
tests/input_checker.sv
tests/tb_mcr3_input.sv

// ==== Bender.yml ====
package:
  name: mcr3_input

sources:
  - rtl/mcr3_input_pkg.sv
  - rtl/player_if.sv
  - rtl/wheel_spinner.sv
  - rtl/derby_wheels.sv
  - rtl/gear_toggles.sv
  - rtl/input_port_mux.sv
  - rtl/mcr3_input_top.sv
  - target: test
    files:
      - tests/input_checker.sv
      - tests/tb_mcr3_input.sv
